/* rtl/hf_pcie_pkg.sv */
// host-side transfer types: completion tag, word index, host address, status, channel
package hf_pcie_pkg;

   typedef logic [7:0]  pcie_tag_t;     // {irq, channel[2:0], rsvd, slot[2:0]}
   typedef logic [5:0]  word_index_t;   // 64-bit word within a block
   typedef logic [63:0] host_addr_t;    // host byte address
   typedef logic [31:0] status_t;       // bytes delivered so far
   typedef logic [2:0]  channel_t;

   localparam int TAG_IRQ_BIT = 7;      // requester wants an interrupt on completion

   // channel field of a completion tag
   function automatic channel_t tag_channel(input pcie_tag_t tag);
      return tag[6:4];
   endfunction

   // reorder slot field of a completion tag
   function automatic logic [2:0] tag_slot(input pcie_tag_t tag);
      return tag[2:0];
   endfunction

endpackage

/* rtl/hf_buffer_pkg.sv */
// card-side storage types: payload word, reorder slot, buffer address, block geometry
package hf_buffer_pkg;

   typedef logic [63:0] data_word_t;    // one completion payload word
   typedef logic [2:0]  slot_t;         // one of eight reorder slots
   typedef logic [8:0]  buf_addr_t;     // {slot, word index}

   localparam int WORDS_PER_BLOCK = 64;
   localparam int BLOCK_BYTES     = 512;

   // requested blocks not yet drained from the RAM
   // kept below 8 so a slot is never reused while it still holds data
   localparam int MAX_OUTSTANDING = 6;

endpackage

/* rtl/hf_completion_if.sv */
// completion word interface with source and sink modports
`timescale 1ns/100ps

interface hf_completion_if
   import hf_pcie_pkg::*, hf_buffer_pkg::*;
   ;

   logic        valid;   // one word per cycle, no back-pressure
   pcie_tag_t   tag;     // channel, slot and irq request
   word_index_t index;   // position within the 512-byte block
   data_word_t  data;

   modport source (
      output valid,
      output tag,
      output index,
      output data
   );

   modport sink (
      input valid,
      input tag,
      input index,
      input data
   );

endinterface

/* rtl/reorder_ram.sv */
// reorder buffer RAM, 512 x 64 simple dual port with registered read
`timescale 1ns/100ps

module reorder_ram
   import hf_buffer_pkg::*;
(
   input  logic       clock,
   input  logic       i_we,       // completion word strobe
   input  buf_addr_t  i_waddr,    // {slot, index}
   input  data_word_t i_wdata,
   input  buf_addr_t  i_raddr,    // drain pointer
   output data_word_t o_rdata     // valid one cycle after i_raddr
);

   data_word_t mem [2**$bits(buf_addr_t)];   // 8 slots x 64 words

   always_ff @(posedge clock) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
   end

   // read register, maps onto the block RAM output latch
   always_ff @(posedge clock) begin
      o_rdata <= mem[i_raddr];
   end

endmodule

/* rtl/stream_fifo.sv */
// single-clock first-word-fall-through FIFO with free-space ready flag
`timescale 1ns/100ps

module stream_fifo
   import hf_buffer_pkg::*;
#(
   parameter int FIFO_DEPTH_LOG2 = 4
) (
   input  logic       clock,
   input  logic       i_arst_n,
   input  logic       i_wvalid,
   input  data_word_t i_wdata,
   output logic       o_ready,    // at least three entries free
   input  logic       i_read,     // pop when o_valid
   output data_word_t o_data,
   output logic       o_valid
);

   localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
   localparam int PW    = FIFO_DEPTH_LOG2 + 1;   // extra bit tells full from empty

   data_word_t   mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [PW-1:0] used;
   logic [PW-1:0] free;
   logic          full;
   logic          pop;

   assign used = wr_ptr - rd_ptr;
   assign free = PW'(DEPTH) - used;
   assign full = (used == PW'(DEPTH));
   assign pop  = i_read && o_valid;

   // two words may already be on their way from the RAM, plus the one issued now
   assign o_ready = (free >= PW'(3));
   assign o_valid = (used != '0);                        // head visible the cycle after write
   assign o_data  = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];    // fall-through head

   always_ff @(posedge clock) begin
      if (i_wvalid) begin
         mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= i_wdata;
      end
   end

   always_ff @(posedge clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (i_wvalid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // the reorder side paces itself on o_ready, so it never overruns
   a_no_write_when_full : assert property (
      @(posedge clock) disable iff (!i_arst_n) i_wvalid |-> !full
   );

endmodule

/* rtl/from_host_reorder.sv */
// completion reorder, slot tracking, request pacing, byte count and interrupt
`timescale 1ns/100ps

module from_host_reorder
   import hf_pcie_pkg::*, hf_buffer_pkg::*;
#(
   parameter channel_t CHANNEL         = 3'd0,
   parameter int       FIFO_DEPTH_LOG2 = 4
) (
   input  logic          clock,
   input  logic          i_arst_n,
   hf_completion_if.sink cpl,
   input  logic          i_rr_ready,     // grant strobe from host
   output logic          o_rr_valid,
   output slot_t         o_rr_slot,
   input  logic          i_fifo_read,
   output data_word_t    o_fifo_data,
   output logic          o_fifo_valid,
   output logic          o_interrupt,
   output status_t       o_status
);

   logic [7:0]  filled;        // slot has its last word
   slot_t       p_request;     // next slot to request
   slot_t       p_write;       // oldest slot not yet complete
   buf_addr_t   p_read;        // drain position, {slot, index}
   slot_t       rd_slot;
   logic [2:0]  n_outstanding; // requested, not yet drained
   logic [1:0]  holdoff;
   logic        rr_enable;     // keeps requests off until after reset
   logic        rr_take;
   slot_t       cpl_slot;
   logic        cpl_write;
   logic        cpl_last;
   buf_addr_t   waddr;
   logic        fifo_ready;
   logic        rd_issue;
   logic        rd_q;          // RAM read in flight
   logic        fifo_wvalid;   // aligned with ram_q
   data_word_t  ram_rdata;
   data_word_t  ram_q;
   status_t     byte_count;

   ////////////////////////////////////////////////////////////
   // completion side
   ////////////////////////////////////////////////////////////
   assign cpl_slot  = slot_t'(tag_slot(cpl.tag));
   assign cpl_write = cpl.valid && (tag_channel(cpl.tag) == CHANNEL);   // other channels ignored
   assign cpl_last  = cpl_write && (cpl.index == word_index_t'(WORDS_PER_BLOCK - 1));
   assign waddr     = {cpl_slot, cpl.index};

   always_ff @(posedge clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         filled <= '0;
      end else begin
         for (int i = 0; i < 8; i++) begin
            if (cpl_last && (cpl_slot == slot_t'(i))) begin
               filled[i] <= 1'b1;              // last word seen
            end else if (p_write == slot_t'(i)) begin
               filled[i] <= 1'b0;              // consumed by write pointer
            end
         end
      end
   end

   always_ff @(posedge clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         p_write     <= '0;
         byte_count  <= '0;
         o_interrupt <= 1'b0;
      end else begin
         p_write     <= p_write + slot_t'(filled[p_write]);   // walk in request order
         o_interrupt <= cpl_last && cpl.tag[TAG_IRQ_BIT];      // single-cycle pulse
         if (cpl_last) begin
            byte_count <= byte_count + status_t'(BLOCK_BYTES);
         end
      end
   end

   assign o_status = byte_count;

   ////////////////////////////////////////////////////////////
   // request pacing
   ////////////////////////////////////////////////////////////
   assign rd_slot       = p_read[8:6];
   assign n_outstanding = p_request - rd_slot;   // never wraps, limit is below 8
   assign o_rr_valid    = rr_enable && (holdoff == '0) && (n_outstanding < MAX_OUTSTANDING);
   assign o_rr_slot     = p_request;
   assign rr_take       = o_rr_valid && i_rr_ready;

   always_ff @(posedge clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rr_enable <= 1'b0;
         holdoff   <= '0;
         p_request <= '0;
      end else begin
         rr_enable <= 1'b1;
         if (rr_take) begin
            holdoff   <= 2'd3;                 // three quiet cycles after each grant
            p_request <= p_request + 1'b1;
         end else if (holdoff != '0) begin
            holdoff <= holdoff - 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // drain to FIFO
   ////////////////////////////////////////////////////////////
   assign rd_issue = (rd_slot != p_write) && fifo_ready;   // complete blocks only

   always_ff @(posedge clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         p_read      <= '0;
         rd_q        <= 1'b0;
         fifo_wvalid <= 1'b0;
      end else begin
         p_read      <= p_read + buf_addr_t'(rd_issue);
         rd_q        <= rd_issue;              // RAM read register stage
         fifo_wvalid <= rd_q;                  // alignment stage
      end
   end

   always_ff @(posedge clock) begin
      ram_q <= ram_rdata;
   end

   reorder_ram reorder_ram_i (
      .clock   (clock),
      .i_we    (cpl_write),
      .i_waddr (waddr),
      .i_wdata (cpl.data),
      .i_raddr (p_read),
      .o_rdata (ram_rdata)
   );

   stream_fifo #(
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) stream_fifo_i (
      .clock    (clock),
      .i_arst_n (i_arst_n),
      .i_wvalid (fifo_wvalid),
      .i_wdata  (ram_q),
      .o_ready  (fifo_ready),
      .i_read   (i_fifo_read),
      .o_data   (o_fifo_data),
      .o_valid  (o_fifo_valid)
   );

   // host must only complete slots that were requested and are still waiting
   a_cpl_slot_outstanding : assert property (
      @(posedge clock) disable iff (!i_arst_n)
      cpl_write |-> (slot_t'(cpl_slot - p_write) < slot_t'(p_request - p_write))
   );

   a_outstanding_limit : assert property (
      @(posedge clock) disable iff (!i_arst_n) n_outstanding <= MAX_OUTSTANDING
   );

endmodule

/* rtl/read_request_gen.sv */
// read request tag and host address generation with interrupt spacing
`timescale 1ns/100ps

module read_request_gen
   import hf_pcie_pkg::*, hf_buffer_pkg::*;
#(
   parameter channel_t CHANNEL      = 3'd0,
   parameter int       IRQ_INTERVAL = 0      // 0 = no interrupts
) (
   input  logic       clock,
   input  logic       i_arst_n,
   input  host_addr_t i_base_addr,
   input  logic       i_rr_valid,
   input  slot_t      i_rr_slot,
   input  logic       i_rr_ready,
   output logic       o_rr_valid,
   output pcie_tag_t  o_rr_tag,
   output host_addr_t o_rr_addr
);

   logic [31:0] block_count;   // blocks granted so far
   logic [15:0] irq_count;     // position within the interrupt interval
   logic        take;
   logic        irq_due;

   assign take    = i_rr_valid && i_rr_ready;
   assign irq_due = (IRQ_INTERVAL != 0) && (irq_count == 16'(IRQ_INTERVAL - 1));

   always_ff @(posedge clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         block_count <= '0;
         irq_count   <= '0;
      end else if (take) begin
         block_count <= block_count + 1'b1;
         irq_count   <= irq_due ? '0 : irq_count + 1'b1;   // every IRQ_INTERVAL-th block
      end
   end

   assign o_rr_valid = i_rr_valid;
   assign o_rr_tag   = {irq_due, CHANNEL, 1'b0, i_rr_slot};
   assign o_rr_addr  = i_base_addr + (host_addr_t'(block_count) << $clog2(BLOCK_BYTES));

   a_addr_aligned : assert property (
      @(posedge clock) disable iff (!i_arst_n) o_rr_valid |-> (o_rr_addr[8:0] == '0)
   );

endmodule

/* rtl/from_host_dma.sv */
// host-to-card DMA read path top level, completion bundling and block instances
`timescale 1ns/100ps

module from_host_dma
   import hf_pcie_pkg::*, hf_buffer_pkg::*;
#(
   parameter channel_t CHANNEL         = 3'd0,
   parameter int       IRQ_INTERVAL    = 0,
   parameter int       FIFO_DEPTH_LOG2 = 4
) (
   input  logic        clock,
   input  logic        i_arst_n,
   input  host_addr_t  i_base_addr,
   // read completion
   input  logic        i_rc_valid,
   input  pcie_tag_t   i_rc_tag,
   input  word_index_t i_rc_index,
   input  data_word_t  i_rc_data,
   // read request
   output logic        o_rr_valid,
   output pcie_tag_t   o_rr_tag,
   output host_addr_t  o_rr_addr,
   input  logic        i_rr_ready,
   // card-side stream
   input  logic        i_fifo_read,
   output data_word_t  o_fifo_data,
   output logic        o_fifo_valid,
   output logic        o_interrupt,
   output status_t     o_status
);

   logic  rr_valid;
   slot_t rr_slot;

   hf_completion_if cpl_if ();

   assign cpl_if.valid = i_rc_valid;
   assign cpl_if.tag   = i_rc_tag;
   assign cpl_if.index = i_rc_index;
   assign cpl_if.data  = i_rc_data;

   from_host_reorder #(
      .CHANNEL         (CHANNEL),
      .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) from_host_reorder_i (
      .clock        (clock),
      .i_arst_n     (i_arst_n),
      .cpl          (cpl_if.sink),
      .i_rr_ready   (i_rr_ready),
      .o_rr_valid   (rr_valid),
      .o_rr_slot    (rr_slot),
      .i_fifo_read  (i_fifo_read),
      .o_fifo_data  (o_fifo_data),
      .o_fifo_valid (o_fifo_valid),
      .o_interrupt  (o_interrupt),
      .o_status     (o_status)
   );

   read_request_gen #(
      .CHANNEL      (CHANNEL),
      .IRQ_INTERVAL (IRQ_INTERVAL)
   ) read_request_gen_i (
      .clock       (clock),
      .i_arst_n    (i_arst_n),
      .i_base_addr (i_base_addr),
      .i_rr_valid  (rr_valid),
      .i_rr_slot   (rr_slot),
      .i_rr_ready  (i_rr_ready),
      .o_rr_valid  (o_rr_valid),
      .o_rr_tag    (o_rr_tag),
      .o_rr_addr   (o_rr_addr)
   );

endmodule

/* test/from_host_dma_tb.sv */
// testbench: clock and reset, LFSR, host request model, completion player, consumer, checks
`timescale 1ns/100ps

module from_host_dma_tb
   import hf_pcie_pkg::*, hf_buffer_pkg::*;
#(
   parameter channel_t CHANNEL      = 3'd2,
   parameter int       IRQ_INTERVAL = 4
) ();

   localparam int         N_BLOCKS    = 40;
   localparam int         TOTAL_WORDS = N_BLOCKS * WORDS_PER_BLOCK;
   localparam int         TIMEOUT     = N_BLOCKS * 200;        // cycles
   localparam int         N_LANES     = 4;                     // blocks interleaved on the link
   localparam int         N_IRQ       = (IRQ_INTERVAL == 0) ? 0 : N_BLOCKS / IRQ_INTERVAL;
   localparam host_addr_t BASE        = 64'h0000_0012_3456_0000;   // 512-aligned

   logic        clock = 1'b0;
   logic        i_arst_n;
   host_addr_t  i_base_addr;
   logic        i_rc_valid;
   pcie_tag_t   i_rc_tag;
   word_index_t i_rc_index;
   data_word_t  i_rc_data;
   logic        o_rr_valid;
   pcie_tag_t   o_rr_tag;
   host_addr_t  o_rr_addr;
   logic        i_rr_ready;
   logic        i_fifo_read;
   data_word_t  o_fifo_data;
   logic        o_fifo_valid;
   logic        o_interrupt;
   status_t     o_status;

   logic [31:0] lfsr;
   logic        running;        // stimulus and checks active
   logic        irq_expect;     // pulse due at the next negedge
   int          errors;
   int          words;          // words popped from the FIFO
   int          granted;
   int          last_words;     // index 63 words sent
   int          irq_pulses;
   int          cycles;
   host_addr_t  exp_data;       // next address expected at the FIFO
   host_addr_t  pend_addr [$];  // granted, not yet on the link
   pcie_tag_t   pend_tag [$];
   host_addr_t  lane_addr [N_LANES];
   pcie_tag_t   lane_tag [N_LANES];
   word_index_t lane_order [N_LANES][WORDS_PER_BLOCK];
   int          lane_pos [N_LANES];   // WORDS_PER_BLOCK when the lane is idle

   always #4 clock = ~clock;   // 8 ns period

   from_host_dma #(
      .CHANNEL         (CHANNEL),
      .IRQ_INTERVAL    (IRQ_INTERVAL),
      .FIFO_DEPTH_LOG2 (4)
   ) from_host_dma_i (
      .clock        (clock),
      .i_arst_n     (i_arst_n),
      .i_base_addr  (i_base_addr),
      .i_rc_valid   (i_rc_valid),
      .i_rc_tag     (i_rc_tag),
      .i_rc_index   (i_rc_index),
      .i_rc_data    (i_rc_data),
      .o_rr_valid   (o_rr_valid),
      .o_rr_tag     (o_rr_tag),
      .o_rr_addr    (o_rr_addr),
      .i_rr_ready   (i_rr_ready),
      .i_fifo_read  (i_fifo_read),
      .o_fifo_data  (o_fifo_data),
      .o_fifo_valid (o_fifo_valid),
      .o_interrupt  (o_interrupt),
      .o_status     (o_status)
   );

   ////////////////////////////////////////////////////////////
   // random source and error reporting
   ////////////////////////////////////////////////////////////
   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr_next(lfsr);   // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      errors++;
      $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR %s at %0t", msg, $time);
   endtask

   ////////////////////////////////////////////////////////////
   // host model
   ////////////////////////////////////////////////////////////
   task automatic load_lane(input int ln);
      logic [31:0] r;
      int          j;
      word_index_t t;
      lane_addr[ln] = pend_addr.pop_front();
      lane_tag[ln]  = pend_tag.pop_front();
      for (int k = 0; k < WORDS_PER_BLOCK; k++) begin
         lane_order[ln][k] = word_index_t'(k);
      end
      // index 63 stays last, it marks the slot filled
      for (int k = WORDS_PER_BLOCK - 2; k > 0; k--) begin
         rand_bits(6, r);
         j                 = int'(r) % (k + 1);
         t                 = lane_order[ln][k];
         lane_order[ln][k] = lane_order[ln][j];
         lane_order[ln][j] = t;
      end
      lane_pos[ln] = 0;
   endtask

   task automatic drive_completion();
      logic [31:0] r;
      int          ln;
      word_index_t idx;
      i_rc_valid = 1'b0;
      for (int k = 0; k < N_LANES; k++) begin
         if (lane_pos[k] == WORDS_PER_BLOCK && pend_addr.size() != 0) begin
            load_lane(k);
         end
      end
      rand_bits(2, r);   // lane to start the search from
      for (int s = 0; s < N_LANES; s++) begin
         ln = (int'(r) + s) % N_LANES;
         if (!i_rc_valid && lane_pos[ln] < WORDS_PER_BLOCK) begin
            idx        = lane_order[ln][lane_pos[ln]];
            i_rc_valid = 1'b1;
            i_rc_tag   = lane_tag[ln];
            i_rc_index = idx;
            i_rc_data  = lane_addr[ln] + host_addr_t'(idx) * 8;   // payload = byte address
            lane_pos[ln]++;
         end
      end
   endtask

   task automatic drive_request();
      host_addr_t exp_addr;
      logic       irq_want;
      if (i_rr_ready) begin
         i_rr_ready = 1'b0;   // grant lasts one cycle
      end else if (o_rr_valid && granted < N_BLOCKS) begin
         exp_addr = BASE + host_addr_t'(granted) * BLOCK_BYTES;
         irq_want = (IRQ_INTERVAL != 0) && ((granted % IRQ_INTERVAL) == IRQ_INTERVAL - 1);
         assert (o_rr_addr == exp_addr)
            else report_mismatch("o_rr_addr", o_rr_addr, exp_addr);
         assert (o_rr_tag[2:0] == 3'(granted % 8))
            else report_mismatch("o_rr_tag slot", o_rr_tag[2:0], granted % 8);
         assert (o_rr_tag[6:4] == CHANNEL)
            else report_mismatch("o_rr_tag channel", o_rr_tag[6:4], CHANNEL);
         assert (o_rr_tag[TAG_IRQ_BIT] == irq_want)
            else report_mismatch("o_rr_tag irq", o_rr_tag[TAG_IRQ_BIT], irq_want);
         pend_addr.push_back(o_rr_addr);
         pend_tag.push_back(o_rr_tag);
         granted++;
         i_rr_ready = 1'b1;
      end
   endtask

   task automatic drive_consumer();
      logic [31:0] r;
      rand_bits(2, r);
      i_fifo_read = (r[1:0] != 2'b00);   // reads three cycles in four
   endtask

   // completions go first, so a block granted now reaches the link a cycle later
   always @(posedge clock) begin
      #1;
      if (running) begin
         drive_completion();
         drive_request();
         drive_consumer();
      end
   end

   ////////////////////////////////////////////////////////////
   // checks at the falling edge
   ////////////////////////////////////////////////////////////
   always @(negedge clock) begin
      if (running) begin
         assert (o_status == status_t'(last_words * BLOCK_BYTES))
            else report_mismatch("o_status", o_status, last_words * BLOCK_BYTES);
         assert (o_interrupt == irq_expect)
            else report_mismatch("o_interrupt", o_interrupt, irq_expect);
         if (o_interrupt) begin
            irq_pulses++;
         end
         // word on the link now is taken at the next rising edge
         irq_expect = i_rc_valid && (i_rc_index == word_index_t'(WORDS_PER_BLOCK - 1))
                      && i_rc_tag[TAG_IRQ_BIT];
         if (i_rc_valid && i_rc_index == word_index_t'(WORDS_PER_BLOCK - 1)) begin
            last_words++;
         end
         if (o_fifo_valid && i_fifo_read) begin
            assert (o_fifo_data == exp_data)
               else report_mismatch("o_fifo_data", o_fifo_data, exp_data);
            exp_data += 8;
            words++;
         end
         // one block may have left the RAM while its tail still sits in the FIFO
         assert (granted - words / WORDS_PER_BLOCK <= MAX_OUTSTANDING + 1)
            else report_error("more blocks outstanding than the request limit allows");
      end
   end

   ////////////////////////////////////////////////////////////
   // reset, run and summary
   ////////////////////////////////////////////////////////////
   initial begin
      lfsr        = 32'h79d9_6efc;
      running     = 1'b0;
      irq_expect  = 1'b0;
      errors      = 0;
      words       = 0;
      granted     = 0;
      last_words  = 0;
      irq_pulses  = 0;
      cycles      = 0;
      exp_data    = BASE;
      i_arst_n    = 1'b0;
      i_base_addr = BASE;
      i_rc_valid  = 1'b0;
      i_rc_tag    = '0;
      i_rc_index  = '0;
      i_rc_data   = '0;
      i_rr_ready  = 1'b0;
      i_fifo_read = 1'b0;
      for (int k = 0; k < N_LANES; k++) begin
         lane_pos[k] = WORDS_PER_BLOCK;
      end
      repeat (10) @(posedge clock);
      #1;
      i_arst_n = 1'b1;
      assert (!o_fifo_valid) else report_mismatch("o_fifo_valid", o_fifo_valid, 0);
      assert (!o_interrupt) else report_mismatch("o_interrupt", o_interrupt, 0);
      assert (o_status == '0) else report_mismatch("o_status", o_status, 0);
      assert (!o_rr_valid) else report_mismatch("o_rr_valid", o_rr_valid, 0);
      @(posedge clock);
      running = 1'b1;
      while (words < TOTAL_WORDS && cycles < TIMEOUT) begin
         @(posedge clock);
         cycles++;
      end
      repeat (4) @(posedge clock);
      if (cycles >= TIMEOUT) begin
         report_error($sformatf("timeout after %0d cycles, %0d of %0d words read",
                                cycles, words, TOTAL_WORDS));
      end
      assert (irq_pulses == N_IRQ) else report_mismatch("interrupt pulses", irq_pulses, N_IRQ);
      assert (granted == N_BLOCKS) else report_mismatch("requests granted", granted, N_BLOCKS);
      $display("errors %0d, words %0d, blocks %0d, interrupts %0d, cycles %0d",
               errors, words, last_words, irq_pulses, cycles);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* hf_dma.f */
rtl/hf_pcie_pkg.sv
rtl/hf_buffer_pkg.sv
rtl/hf_completion_if.sv
rtl/reorder_ram.sv
rtl/stream_fifo.sv
rtl/from_host_reorder.sv
rtl/read_request_gen.sv
rtl/from_host_dma.sv
test/from_host_dma_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= from_host_dma_tb
FILELIST  ?= hf_dma.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_LINE ?= ALL TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run succeeds only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_LINE)'

clean:
	rm -rf $(BUILD_DIR)
